// ==== Bender.yml ====
package:
  name: gpgpu_mem_loader

sources:
  - src/gpgpu_loader_pkg.sv
  - src/hex_row_loader.sv
  - src/file_dump_sequencer.sv
  - src/gpgpu_mem_loader.sv
  - target: simulation
    files:
      - sim/tb_row_mem.sv
      - sim/tb_gpgpu_mem_loader.sv

// ==== gpgpu_mem_loader.f ====
src/gpgpu_loader_pkg.sv
src/hex_row_loader.sv
src/file_dump_sequencer.sv
src/gpgpu_mem_loader.sv
sim/tb_row_mem.sv
sim/tb_gpgpu_mem_loader.sv

// ==== sim/tb_gpgpu_mem_loader.sv ====
`timescale 1ns/1ps

module tb_gpgpu_mem_loader;

  localparam int task_rows = 4;
  localparam int ic_rows   = 3;
  localparam int dc_rows   = 2;
  localparam int addr_w    = 10;

  // one table entry per step
  typedef struct packed {
    logic       is_dump;  // 0 loads a file and 1 starts a readback
    logic [7:0] id;       // file id for loads
    logic [3:0] filler;   // non-hex bytes after the first digit of each row
    logic       lower;    // odd digits sent in lower case
    logic [2:0] leds;     // file_leds expected after the step
  } step_t;

  localparam int n_steps = 6;

  step_t steps [0:n_steps-1] = '{
    {1'b1, 8'h00, 4'd0, 1'b0, 3'b000},  // dump before loaded is ignored
    {1'b0, 8'h00, 4'd2, 1'b1, 3'b001},  // task file in mixed case
    {1'b0, 8'h07, 4'd1, 1'b0, 3'b001},  // unknown id gives no writes
    {1'b0, 8'h01, 4'd1, 1'b1, 3'b011},  // icache in mixed case
    {1'b0, 8'h10, 4'd3, 1'b1, 3'b111},  // dcache arms the readback
    {1'b1, 8'h00, 4'd0, 1'b0, 3'b111}   // full readback
  };

  // ascii digit strings with digit 0 in the top byte
  localparam logic [127:0] upper_digits = "0123456789ABCDEF";
  localparam logic [127:0] lower_digits = "0123456789abcdef";

  logic                        clk_sys;
  logic                        rst_clk;
  logic [7:0]                  rx_data;
  logic                        rx_valid;
  logic                        tx_full;
  logic                        start_dump;
  logic [7:0]                  tx_data;
  logic                        tx_valid;
  logic                        task_init;
  logic                        ic_init;
  logic                        dc_init;
  logic [addr_w-1:0]           wr_addr;
  gpgpu_loader_pkg::row_word_u row_data;
  logic [addr_w-1:0]           task_rd_addr;
  logic [addr_w-1:0]           ic_rd_addr;
  logic [addr_w-1:0]           dc_rd_addr;
  logic [31:0]                 task_dout;
  logic [31:0]                 ic_dout;
  logic [255:0]                dc_dout;
  logic [2:0]                  file_leds;
  logic                        loaded;
  logic                        dump_done;

  // testbench state
  logic [31:0]  lfsr;
  logic [31:0]  exp_task [0:task_rows-1];
  logic [31:0]  exp_ic   [0:ic_rows-1];
  logic [255:0] exp_dc   [0:dc_rows-1];
  logic [7:0]   got_bytes [$];
  logic [7:0]   exp_bytes [$];
  int           arm_tgt;        // target whose strobes are allowed or 3 for none
  int           arm_rows;
  int           wr_seen;        // strobes seen in the current file
  int           tx_count;
  logic         dump_on;        // tx bytes are legal
  logic         done_seen;
  logic         dc_loaded_exp;

  gpgpu_mem_loader #(
    .task_rows (task_rows),
    .ic_rows   (ic_rows),
    .dc_rows   (dc_rows),
    .addr_w    (addr_w)
  ) u_gpgpu_mem_loader (
    .clk_sys      (clk_sys),
    .rst_clk      (rst_clk),
    .rx_data      (rx_data),
    .rx_valid     (rx_valid),
    .tx_full      (tx_full),
    .tx_data      (tx_data),
    .tx_valid     (tx_valid),
    .start_dump   (start_dump),
    .task_init    (task_init),
    .ic_init      (ic_init),
    .dc_init      (dc_init),
    .wr_addr      (wr_addr),
    .row_data     (row_data),
    .task_rd_addr (task_rd_addr),
    .ic_rd_addr   (ic_rd_addr),
    .dc_rd_addr   (dc_rd_addr),
    .task_dout    (task_dout),
    .ic_dout      (ic_dout),
    .dc_dout      (dc_dout),
    .file_leds    (file_leds),
    .loaded       (loaded),
    .dump_done    (dump_done)
  );

  tb_row_mem #(.width(32), .depth(task_rows), .addr_w(addr_w)) u_task_mem (
    .clk_sys (clk_sys),
    .we      (task_init),
    .wr_addr (wr_addr),
    .wr_data (row_data.narrow.word),
    .rd_addr (task_rd_addr),
    .rd_data (task_dout)
  );

  tb_row_mem #(.width(32), .depth(ic_rows), .addr_w(addr_w)) u_ic_mem (
    .clk_sys (clk_sys),
    .we      (ic_init),
    .wr_addr (wr_addr),
    .wr_data (row_data.narrow.word),
    .rd_addr (ic_rd_addr),
    .rd_data (ic_dout)
  );

  tb_row_mem #(.width(256), .depth(dc_rows), .addr_w(addr_w)) u_dc_mem (
    .clk_sys (clk_sys),
    .we      (dc_init),
    .wr_addr (wr_addr),
    .wr_data (row_data.wide),
    .rd_addr (dc_rd_addr),
    .rd_data (dc_dout)
  );

  always #50 clk_sys = ~clk_sys;  // 100 ns period

  // *************************************************************************
  // helpers
  // *************************************************************************

  task automatic stop_on_error(input string msg);
    $display("%s", msg);
    $display("STATUS: FAIL");
    $fatal(1);
  endtask

  // fibonacci lfsr with taps 32 22 2 1
  function automatic logic [31:0] lfsr_next(input logic [31:0] s);
    return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
  endfunction

  task automatic take_bits(input int n, output logic [255:0] v);
    int i;
    v = '0;
    for (i = 0; i < n; i++) begin
      lfsr = lfsr_next(lfsr);  // one step per bit
      v    = {v[254:0], lfsr[0]};
    end
  endtask

  function automatic logic [7:0] hex_char(input logic [3:0] v, input logic lower);
    return lower ? lower_digits[8 * (15 - v) +: 8] : upper_digits[8 * (15 - v) +: 8];
  endfunction

  function automatic int tgt_of(input logic [7:0] id);
    case (id)
      8'h00:   return 0;
      8'h01:   return 1;
      8'h10:   return 2;
      default: return 3;
    endcase
  endfunction

  function automatic int rows_of(input int tgt);
    return (tgt == 0) ? task_rows : (tgt == 1) ? ic_rows : (tgt == 2) ? dc_rows : 2;
  endfunction

  function automatic int nibs_of(input int tgt);
    return (tgt == 2) ? 64 : 8;
  endfunction

  // bytes of the whole readback stream
  function automatic int dump_len();
    return 27 + 10 * task_rows + 10 * ic_rows + 66 * dc_rows;
  endfunction

  function automatic int watchdog_cycles();
    int i;
    int cyc;
    int t;
    cyc = 200;  // reset and slack
    for (i = 0; i < n_steps; i++) begin
      t = tgt_of(steps[i].id);
      if (steps[i].is_dump) begin
        cyc += 20 * dump_len() + 40;
      end else begin
        cyc += 40 * (8 + rows_of(t) * (nibs_of(t) + int'(steps[i].filler) + 2));
      end
    end
    return cyc;
  endfunction

  // host byte held for one clock
  task automatic send_byte(input logic [7:0] b);
    rx_data  = b;
    rx_valid = 1'b1;
    @(posedge clk_sys);
    #10;
    rx_valid = 1'b0;
  endtask

  // *************************************************************************
  // write and tx monitor sampled mid-cycle
  // *************************************************************************

  task automatic check_write();
    int t;
    t = task_init ? 0 : (ic_init ? 1 : 2);
    assert (int'(task_init) + int'(ic_init) + int'(dc_init) == 1)
      else stop_on_error("more than one write strobe in the same cycle");
    assert ((t == arm_tgt) && (wr_seen < arm_rows))
      else stop_on_error($sformatf("unexpected write strobe for target %0d at %0t", t, $time));
    assert (wr_addr == wr_seen)
      else stop_on_error($sformatf("mismatch %0t: wr_addr %0d, expected %0d",
                                   $time, wr_addr, wr_seen));
    if (t == 0) begin
      assert (row_data.narrow.word == exp_task[wr_seen])
        else stop_on_error($sformatf("mismatch %0t: task row %0d is %h, expected %h",
                                     $time, wr_seen, row_data.narrow.word, exp_task[wr_seen]));
    end else if (t == 1) begin
      assert (row_data.narrow.word == exp_ic[wr_seen])
        else stop_on_error($sformatf("mismatch %0t: icache row %0d is %h, expected %h",
                                     $time, wr_seen, row_data.narrow.word, exp_ic[wr_seen]));
    end else begin
      assert (row_data.wide == exp_dc[wr_seen])
        else stop_on_error($sformatf("mismatch %0t: dcache row %0d is %h, expected %h",
                                     $time, wr_seen, row_data.wide, exp_dc[wr_seen]));
      // loaded rises together with the last dcache strobe
      assert (loaded == (wr_seen == dc_rows - 1))
        else stop_on_error($sformatf("mismatch %0t: loaded is %b at dcache write %0d",
                                     $time, loaded, wr_seen));
    end
    wr_seen++;
  endtask

  always @(negedge clk_sys) begin
    if (rst_clk === 1'b0) begin
      if (task_init || ic_init || dc_init) check_write();
      if (tx_valid) begin
        assert (!tx_full) else stop_on_error("tx_valid was high while tx_full was high");
        assert (dump_on) else stop_on_error("tx_valid went high with no dump running");
        got_bytes.push_back(tx_data);
        tx_count++;
      end
      if (dump_done) done_seen = 1'b1;
    end
  end

  // *************************************************************************
  // file load and readback steps
  // *************************************************************************

  task automatic load_file(input logic [7:0] id, input int filler, input logic lower);
    int t;
    int rows;
    int nibs;
    int r;
    int n;
    int f;
    logic [255:0] row;
    logic [2:0]   strb;
    t    = tgt_of(id);
    rows = rows_of(t);
    nibs = nibs_of(t);
    if (t != 2 && !dc_loaded_exp) begin
      assert (!loaded) else stop_on_error($sformatf("mismatch %0t: loaded high early", $time));
    end
    arm_tgt  = t;
    arm_rows = (t == 3) ? 0 : rows;  // unknown id must not write
    wr_seen  = 0;
    send_byte("x");  // junk before soh
    send_byte(gpgpu_loader_pkg::soh);
    send_byte(id);
    send_byte(gpgpu_loader_pkg::eot);
    send_byte("n");
    send_byte(gpgpu_loader_pkg::sot);
    for (r = 0; r < rows; r++) begin
      take_bits(nibs * 4, row);
      if (t == 0) exp_task[r] = row[31:0];
      if (t == 1) exp_ic[r] = row[31:0];
      if (t == 2) exp_dc[r] = row;
      for (n = 0; n < nibs; n++) begin
        send_byte(hex_char(row[nibs * 4 - 1 - 4 * n -: 4], lower && n[0]));
        if (n == 0) begin
          for (f = 0; f < filler; f++) send_byte(f[0] ? "z" : " ");
        end
      end
      strb = {dc_init, ic_init, task_init};  // due one cycle after the last digit
      if (t != 3) begin
        assert (strb[t])
          else stop_on_error($sformatf("mismatch %0t: no write strobe right after row %0d",
                                       $time, r));
      end
      send_byte(gpgpu_loader_pkg::cr);
      send_byte(gpgpu_loader_pkg::lf);
    end
    repeat (2) @(posedge clk_sys);
    #10;
    assert (wr_seen == arm_rows)
      else stop_on_error($sformatf("mismatch %0t: %0d writes for id %h, expected %0d",
                                   $time, wr_seen, id, arm_rows));
    if (t == 2) dc_loaded_exp = 1'b1;
    arm_tgt = 3;
  endtask

  task automatic append_file(input logic [39:0] name, input int t);
    int r;
    int n;
    int nibs;
    logic [255:0] w;
    nibs = nibs_of(t);
    exp_bytes.push_back(gpgpu_loader_pkg::soh);
    for (n = 4; n >= 0; n--) exp_bytes.push_back(name[8 * n +: 8]);  // msb first
    exp_bytes.push_back(gpgpu_loader_pkg::eot);
    exp_bytes.push_back(gpgpu_loader_pkg::sot);
    for (r = 0; r < rows_of(t); r++) begin
      w = (t == 2) ? exp_dc[r] : (t == 1) ? {224'b0, exp_ic[r]} : {224'b0, exp_task[r]};
      for (n = 0; n < nibs; n++) exp_bytes.push_back(hex_char(w[nibs * 4 - 1 - 4 * n -: 4], 1'b0));
      exp_bytes.push_back(gpgpu_loader_pkg::cr);
      exp_bytes.push_back(gpgpu_loader_pkg::lf);
    end
    exp_bytes.push_back(gpgpu_loader_pkg::eof);
  endtask

  task automatic run_dump();
    logic [255:0] rnd;
    int i;
    got_bytes.delete();
    exp_bytes.delete();
    tx_count  = 0;
    done_seen = 1'b0;
    dump_on   = dc_loaded_exp;  // only an armed loader may answer
    start_dump = 1'b1;
    @(posedge clk_sys);
    #10;
    start_dump = 1'b0;
    if (!dc_loaded_exp) begin
      repeat (20) @(posedge clk_sys);
      #10;
      assert ((tx_count == 0) && !done_seen)
        else stop_on_error("start_dump before loaded started a readback");
    end else begin
      fork
        begin : sink_side
          while (!done_seen) begin
            take_bits(2, rnd);
            tx_full = (rnd[1:0] == 2'b00);  // full about a quarter of the time
            @(posedge clk_sys);
            #10;
          end
          tx_full = 1'b0;
        end
        begin : host_side
          wait (tx_count > 0);  // readback is running
          @(posedge clk_sys);
          #10;
          send_byte(gpgpu_loader_pkg::soh);
          send_byte(gpgpu_loader_pkg::file_id_task);
          send_byte(gpgpu_loader_pkg::eot);
          send_byte(gpgpu_loader_pkg::sot);
          for (i = 0; i < 8; i++) send_byte(8'h31 + i[7:0]);
        end
      join
      repeat (2) @(posedge clk_sys);
      #10;
      dump_on = 1'b0;
      append_file("Test1", 0);
      append_file("Test2", 1);
      append_file("Test3", 2);
      assert (got_bytes.size() == exp_bytes.size())
        else stop_on_error($sformatf("mismatch %0t: %0d bytes sent, expected %0d",
                                     $time, got_bytes.size(), exp_bytes.size()));
      for (i = 0; i < exp_bytes.size(); i++) begin
        assert (got_bytes[i] == exp_bytes[i])
          else stop_on_error($sformatf("mismatch %0t: byte %0d is %h, expected %h",
                                       $time, i, got_bytes[i], exp_bytes[i]));
      end
    end
  endtask

  // *************************************************************************
  // main sequence and watchdog
  // *************************************************************************

  initial begin
    step_t st;
    int    i;
    clk_sys       = 1'b0;
    rst_clk       = 1'b1;
    rx_data       = 8'h00;
    rx_valid      = 1'b0;
    tx_full       = 1'b0;
    start_dump    = 1'b0;
    lfsr          = 32'h6acd;
    arm_tgt       = 3;
    arm_rows      = 0;
    wr_seen       = 0;
    tx_count      = 0;
    dump_on       = 1'b0;
    done_seen     = 1'b0;
    dc_loaded_exp = 1'b0;
    repeat (8) @(posedge clk_sys);
    #10;
    assert (!task_init && !ic_init && !dc_init && !tx_valid && file_leds == 3'b000 &&
            !loaded && !dump_done)
      else stop_on_error($sformatf("mismatch %0t: outputs not idle after reset", $time));
    rst_clk = 1'b0;
    for (i = 0; i < n_steps; i++) begin
      st = steps[i];
      if (st.is_dump) run_dump();
      else load_file(st.id, int'(st.filler), st.lower);
      assert (file_leds == st.leds)
        else stop_on_error($sformatf("mismatch %0t: file_leds %b after step %0d, expected %b",
                                     $time, file_leds, i, st.leds));
    end
    $display("STATUS: PASS");
    $finish;
  end

  initial begin
    int lim;
    lim = watchdog_cycles();
    repeat (lim) @(posedge clk_sys);
    stop_on_error("timeout: the run did not finish within the watchdog limit");
  end

endmodule

// ==== sim/tb_row_mem.sv ====
`timescale 1ns/1ps

// simple row memory, one write port and a registered read port
module tb_row_mem #(
  parameter int width  = 32,
  parameter int depth  = 4,
  parameter int addr_w = 10
) (
  input  logic              clk_sys,
  input  logic              we,        // one-cycle init strobe
  input  logic [addr_w-1:0] wr_addr,
  input  logic [width-1:0]  wr_data,
  input  logic [addr_w-1:0] rd_addr,
  output logic [width-1:0]  rd_data    // valid one cycle after rd_addr
);

  logic [width-1:0] mem [0:depth-1];

  always @(posedge clk_sys) begin
    if (we) begin
      mem[wr_addr] <= wr_data;
    end
    rd_data <= mem[rd_addr];  // read latency of one cycle
  end

endmodule

// ==== src/file_dump_sequencer.sv ====
`timescale 1ns/1ps

module file_dump_sequencer #(
  parameter int task_rows = 256,
  parameter int ic_rows   = 1024,
  parameter int dc_rows   = 512,
  parameter int addr_w    = 10
) (
  input  logic                clk_sys,
  input  logic                rst_clk,
  input  logic                start_dump,
  input  logic                all_loaded,
  input  logic                tx_full,      // sink cannot take a byte
  input  logic [31:0]         task_dout,
  input  logic [31:0]         ic_dout,
  input  logic [255:0]        dc_dout,
  output logic [addr_w-1:0]   task_rd_addr,
  output logic [addr_w-1:0]   ic_rd_addr,
  output logic [addr_w-1:0]   dc_rd_addr,
  output logic [7:0]          tx_data,
  output logic                tx_valid,
  output logic                dump_busy,
  output logic                dump_done
);

  // phase inside one file
  localparam logic [1:0] ph_hdr = 2'd0;  // soh, name, eot, sot
  localparam logic [1:0] ph_row = 2'd1;  // hex chars then cr lf
  localparam logic [1:0] ph_eof = 2'd2;

  // send order
  localparam logic [1:0] f_task = 2'd0;
  localparam logic [1:0] f_ic   = 2'd1;
  localparam logic [1:0] f_dc   = 2'd2;

  localparam logic [addr_w-1:0] task_last = addr_w'(task_rows - 1);
  localparam logic [addr_w-1:0] ic_last   = addr_w'(ic_rows - 1);
  localparam logic [addr_w-1:0] dc_last   = addr_w'(dc_rows - 1);

  logic [1:0]                  phase;
  logic [1:0]                  file_sel;
  logic [2:0]                  hdr_cnt;    // 0 soh, 1..5 name, 6 eot, 7 sot
  logic [6:0]                  chr_cnt;    // hex index, then cr and lf
  logic                        eof_due;    // row being closed is the last one
  logic                        adv;        // a byte leaves this cycle
  logic [addr_w-1:0]           cur_addr;
  logic [addr_w-1:0]           cur_last;
  logic [39:0]                 cur_name;
  logic [6:0]                  cur_chars;
  gpgpu_loader_pkg::row_word_u rd_word;

  assign adv      = dump_busy && !tx_full;
  assign tx_valid = adv;

  // *************************************************************************
  // per file selection
  // *************************************************************************

  always_comb begin
    rd_word = '0;
    case (file_sel)
      f_task: begin
        cur_addr            = task_rd_addr;
        cur_last            = task_last;
        cur_name            = gpgpu_loader_pkg::out_name_task;
        rd_word.narrow.word = task_dout;
      end
      f_ic: begin
        cur_addr            = ic_rd_addr;
        cur_last            = ic_last;
        cur_name            = gpgpu_loader_pkg::out_name_ic;
        rd_word.narrow.word = ic_dout;
      end
      default: begin
        cur_addr     = dc_rd_addr;
        cur_last     = dc_last;
        cur_name     = gpgpu_loader_pkg::out_name_dc;
        rd_word.wide = dc_dout;
      end
    endcase
    cur_chars = (file_sel == f_dc) ? 7'(gpgpu_loader_pkg::wide_nibbles)
                                   : 7'(gpgpu_loader_pkg::narrow_nibbles);
  end

  // outgoing byte
  always_comb begin
    tx_data = gpgpu_loader_pkg::eof;
    case (phase)
      ph_hdr: begin
        case (hdr_cnt)
          3'd0:    tx_data = gpgpu_loader_pkg::soh;
          3'd1:    tx_data = cur_name[39:32];
          3'd2:    tx_data = cur_name[31:24];
          3'd3:    tx_data = cur_name[23:16];
          3'd4:    tx_data = cur_name[15:8];
          3'd5:    tx_data = cur_name[7:0];
          3'd6:    tx_data = gpgpu_loader_pkg::eot;
          default: tx_data = gpgpu_loader_pkg::sot;
        endcase
      end
      ph_row: begin
        if (chr_cnt < cur_chars) begin
          if (file_sel == f_dc) begin
            tx_data = gpgpu_loader_pkg::val_to_hex(
                rd_word.wide[(gpgpu_loader_pkg::wide_w - 1) - 4 * chr_cnt -: 4]);
          end else begin
            tx_data = gpgpu_loader_pkg::val_to_hex(
                rd_word.narrow.word[(gpgpu_loader_pkg::narrow_w - 1) - 4 * chr_cnt -: 4]);
          end
        end else if (chr_cnt == cur_chars) begin
          tx_data = gpgpu_loader_pkg::cr;
        end else begin
          tx_data = gpgpu_loader_pkg::lf;
        end
      end
      default: tx_data = gpgpu_loader_pkg::eof;
    endcase
  end

  // *************************************************************************
  // sequencing, everything holds while the sink is full
  // *************************************************************************

  always_ff @(posedge clk_sys) begin
    if (rst_clk) begin
      dump_busy    <= 1'b0;
      dump_done    <= 1'b0;
      phase        <= ph_hdr;
      file_sel     <= f_task;
      hdr_cnt      <= '0;
      chr_cnt      <= '0;
      eof_due      <= 1'b0;
      task_rd_addr <= '0;
      ic_rd_addr   <= '0;
      dc_rd_addr   <= '0;
    end else begin
      dump_done <= 1'b0;
      if (!dump_busy) begin
        if (start_dump && all_loaded) begin
          dump_busy    <= 1'b1;
          phase        <= ph_hdr;
          file_sel     <= f_task;
          hdr_cnt      <= '0;
          chr_cnt      <= '0;
          eof_due      <= 1'b0;
          task_rd_addr <= '0;  // all three sit at row 0 so the first words are ready
          ic_rd_addr   <= '0;
          dc_rd_addr   <= '0;
        end
      end else if (adv) begin
        case (phase)
          ph_hdr: begin
            if (hdr_cnt == 3'd7) begin
              phase   <= ph_row;
              chr_cnt <= '0;
            end else begin
              hdr_cnt <= hdr_cnt + 3'd1;
            end
          end
          ph_row: begin
            if (chr_cnt == cur_chars) begin
              // cr goes out, step the address so the next word lands by its first char
              chr_cnt <= chr_cnt + 7'd1;
              if (cur_addr == cur_last) begin
                eof_due <= 1'b1;
              end else begin
                case (file_sel)
                  f_task:  task_rd_addr <= task_rd_addr + addr_w'(1);
                  f_ic:    ic_rd_addr   <= ic_rd_addr + addr_w'(1);
                  default: dc_rd_addr   <= dc_rd_addr + addr_w'(1);
                endcase
              end
            end else if (chr_cnt == cur_chars + 7'd1) begin
              chr_cnt <= '0;  // lf closes the row
              if (eof_due) begin
                phase   <= ph_eof;
                eof_due <= 1'b0;
              end
            end else begin
              chr_cnt <= chr_cnt + 7'd1;
            end
          end
          default: begin
            hdr_cnt <= '0;
            if (file_sel == f_dc) begin
              dump_busy <= 1'b0;  // last eof sent
              dump_done <= 1'b1;
            end else begin
              file_sel <= file_sel + 2'd1;
              phase    <= ph_hdr;
            end
          end
        endcase
      end
    end
  end

endmodule

// ==== src/gpgpu_loader_pkg.sv ====
package gpgpu_loader_pkg;

  // *************************************************************************
  // framing characters on the host link
  // *************************************************************************

  localparam logic [7:0] soh = 8'h01;  // start of header
  localparam logic [7:0] sot = 8'h02;  // start of text, data follows
  localparam logic [7:0] eot = 8'h03;  // end of name field
  localparam logic [7:0] eof = 8'h04;  // end of file
  localparam logic [7:0] lf  = 8'h0a;
  localparam logic [7:0] cr  = 8'h0d;

  // target ids carried in the header byte after soh
  localparam logic [7:0] file_id_task = 8'h00;
  localparam logic [7:0] file_id_ic   = 8'h01;
  localparam logic [7:0] file_id_dc   = 8'h10;

  // *************************************************************************
  // row geometry
  // *************************************************************************

  localparam int narrow_w       = 32;   // task and icache rows
  localparam int wide_w         = 256;  // dcache rows
  localparam int narrow_nibbles = narrow_w / 4;
  localparam int wide_nibbles   = wide_w / 4;

  // names of the files sent back, msb first
  localparam logic [39:0] out_name_task = 40'h54_65_73_74_31;  // "Test1"
  localparam logic [39:0] out_name_ic   = 40'h54_65_73_74_32;  // "Test2"
  localparam logic [39:0] out_name_dc   = 40'h54_65_73_74_33;  // "Test3"

  // narrow view keeps the 32-bit word in the low bits
  typedef struct packed {
    logic [wide_w-narrow_w-1:0] pad;
    logic [narrow_w-1:0]        word;
  } narrow_row_t;

  // one memory row, read as a full dcache line or as a narrow word
  typedef union packed {
    logic [wide_w-1:0] wide;
    narrow_row_t       narrow;
  } row_word_u;

  // *************************************************************************
  // hex conversion
  // *************************************************************************

  // bit 4 set when ch is a hex digit, bits 3:0 hold its value
  function automatic logic [4:0] hex_to_val(input logic [7:0] ch);
    logic [4:0] res;
    res = 5'h00;  // not a digit
    if ((ch >= 8'h30) && (ch <= 8'h39)) begin
      res = {1'b1, ch[3:0]};  // 0-9
    end else if (((ch >= 8'h41) && (ch <= 8'h46)) ||
                 ((ch >= 8'h61) && (ch <= 8'h66))) begin
      res = {1'b1, ch[3:0] + 4'd9};  // a-f and A-F give 10..15
    end
    return res;
  endfunction

  // value to ascii, upper case letters
  function automatic logic [7:0] val_to_hex(input logic [3:0] val);
    logic [7:0] ch;
    if (val < 4'd10) begin
      ch = {4'h3, val};
    end else begin
      ch = 8'h37 + {4'h0, val};  // 10 -> 'A'
    end
    return ch;
  endfunction

endpackage

// ==== src/gpgpu_mem_loader.sv ====
`timescale 1ns/1ps

module gpgpu_mem_loader #(
  parameter int task_rows = 256,
  parameter int ic_rows   = 1024,
  parameter int dc_rows   = 512,
  parameter int addr_w    = 10   // covers the deepest memory
) (
  input  logic                        clk_sys,
  input  logic                        rst_clk,
  // host byte stream in
  input  logic [7:0]                  rx_data,
  input  logic                        rx_valid,
  // host byte stream out
  input  logic                        tx_full,
  output logic [7:0]                  tx_data,
  output logic                        tx_valid,
  input  logic                        start_dump,   // clean single-cycle pulse
  // shared write port of the three memories
  output logic                        task_init,
  output logic                        ic_init,
  output logic                        dc_init,
  output logic [addr_w-1:0]           wr_addr,
  output gpgpu_loader_pkg::row_word_u row_data,
  // readback ports, data one cycle after address
  output logic [addr_w-1:0]           task_rd_addr,
  output logic [addr_w-1:0]           ic_rd_addr,
  output logic [addr_w-1:0]           dc_rd_addr,
  input  logic [31:0]                 task_dout,
  input  logic [31:0]                 ic_dout,
  input  logic [255:0]                dc_dout,
  // status
  output logic [2:0]                  file_leds,
  output logic                        loaded,
  output logic                        dump_done
);

  logic dump_busy;  // loader stays deaf while the readback runs

  // *************************************************************************
  // receive side
  // *************************************************************************

  hex_row_loader #(
    .task_rows (task_rows),
    .ic_rows   (ic_rows),
    .dc_rows   (dc_rows),
    .addr_w    (addr_w)
  ) u_loader (
    .clk_sys    (clk_sys),
    .rst_clk    (rst_clk),
    .rx_data    (rx_data),
    .rx_valid   (rx_valid),
    .dump_busy  (dump_busy),
    .task_init  (task_init),
    .ic_init    (ic_init),
    .dc_init    (dc_init),
    .wr_addr    (wr_addr),
    .row_data   (row_data),
    .file_leds  (file_leds),
    .all_loaded (loaded)      // arms the readback
  );

  // *************************************************************************
  // send side
  // *************************************************************************

  file_dump_sequencer #(
    .task_rows (task_rows),
    .ic_rows   (ic_rows),
    .dc_rows   (dc_rows),
    .addr_w    (addr_w)
  ) u_dump (
    .clk_sys      (clk_sys),
    .rst_clk      (rst_clk),
    .start_dump   (start_dump),
    .all_loaded   (loaded),
    .tx_full      (tx_full),
    .task_dout    (task_dout),
    .ic_dout      (ic_dout),
    .dc_dout      (dc_dout),
    .task_rd_addr (task_rd_addr),
    .ic_rd_addr   (ic_rd_addr),
    .dc_rd_addr   (dc_rd_addr),
    .tx_data      (tx_data),
    .tx_valid     (tx_valid),
    .dump_busy    (dump_busy),
    .dump_done    (dump_done)
  );

endmodule

// ==== src/hex_row_loader.sv ====
`timescale 1ns/1ps

module hex_row_loader #(
  parameter int task_rows = 256,
  parameter int ic_rows   = 1024,
  parameter int dc_rows   = 512,
  parameter int addr_w    = 10
) (
  input  logic                        clk_sys,
  input  logic                        rst_clk,
  input  logic [7:0]                  rx_data,
  input  logic                        rx_valid,
  input  logic                        dump_busy,   // readback owns the link
  output logic                        task_init,
  output logic                        ic_init,
  output logic                        dc_init,
  output logic [addr_w-1:0]           wr_addr,
  output gpgpu_loader_pkg::row_word_u row_data,
  output logic [2:0]                  file_leds,   // one per target, set on sot
  output logic                        all_loaded
);

  // header fsm encodings
  localparam logic [2:0] st_idle = 3'd0;  // hunting for soh
  localparam logic [2:0] st_id   = 3'd1;  // next byte is the file id
  localparam logic [2:0] st_eot  = 3'd2;
  localparam logic [2:0] st_sot  = 3'd3;  // name bytes until sot
  localparam logic [2:0] st_data = 3'd4;

  // target select, doubles as file_leds index
  localparam logic [1:0] tgt_task = 2'd0;
  localparam logic [1:0] tgt_ic   = 2'd1;
  localparam logic [1:0] tgt_dc   = 2'd2;

  localparam logic [addr_w-1:0] task_last = addr_w'(task_rows - 1);
  localparam logic [addr_w-1:0] ic_last   = addr_w'(ic_rows - 1);
  localparam logic [addr_w-1:0] dc_last   = addr_w'(dc_rows - 1);

  logic [2:0]        state;
  logic [1:0]        tgt;
  logic [5:0]        nib_cnt;   // nibble position inside current row
  logic [addr_w-1:0] row_cnt;
  logic              rx_take;
  logic [4:0]        hex;       // {valid, value}
  logic              last_nib;
  logic              last_row;

  assign rx_take = rx_valid && !dump_busy;  // bytes during readback are dropped
  assign hex     = gpgpu_loader_pkg::hex_to_val(rx_data);

  // end of row and end of file per target
  always_comb begin
    case (tgt)
      tgt_task: begin
        last_nib = (nib_cnt == 6'(gpgpu_loader_pkg::narrow_nibbles - 1));
        last_row = (row_cnt == task_last);
      end
      tgt_ic: begin
        last_nib = (nib_cnt == 6'(gpgpu_loader_pkg::narrow_nibbles - 1));
        last_row = (row_cnt == ic_last);
      end
      default: begin
        last_nib = (nib_cnt == 6'(gpgpu_loader_pkg::wide_nibbles - 1));
        last_row = (row_cnt == dc_last);
      end
    endcase
  end

  // *************************************************************************
  // header parse and row counting
  // *************************************************************************

  always_ff @(posedge clk_sys) begin
    if (rst_clk) begin
      state      <= st_idle;
      tgt        <= tgt_task;
      nib_cnt    <= '0;
      row_cnt    <= '0;
      task_init  <= 1'b0;
      ic_init    <= 1'b0;
      dc_init    <= 1'b0;
      file_leds  <= '0;
      all_loaded <= 1'b0;
    end else begin
      // write strobes are single cycle
      task_init <= 1'b0;
      ic_init   <= 1'b0;
      dc_init   <= 1'b0;
      if (rx_take) begin
        case (state)
          st_idle: begin
            if (rx_data == gpgpu_loader_pkg::soh) state <= st_id;
          end
          st_id: begin
            nib_cnt <= '0;
            row_cnt <= '0;
            state   <= st_eot;
            case (rx_data)
              gpgpu_loader_pkg::file_id_task: tgt <= tgt_task;
              gpgpu_loader_pkg::file_id_ic:   tgt <= tgt_ic;
              gpgpu_loader_pkg::file_id_dc:   tgt <= tgt_dc;
              default:                        state <= st_idle;  // unknown target
            endcase
          end
          st_eot: begin
            state <= (rx_data == gpgpu_loader_pkg::eot) ? st_sot : st_idle;
          end
          st_sot: begin
            if (rx_data == gpgpu_loader_pkg::sot) begin
              state          <= st_data;
              file_leds[tgt] <= 1'b1;
            end
          end
          st_data: begin
            if (hex[4]) begin  // filler and line endings skipped
              if (last_nib) begin
                nib_cnt   <= '0;
                task_init <= (tgt == tgt_task);
                ic_init   <= (tgt == tgt_ic);
                dc_init   <= (tgt == tgt_dc);
                if (last_row) begin
                  state <= st_idle;
                  if (tgt == tgt_dc) all_loaded <= 1'b1;  // dcache always comes last
                end else begin
                  row_cnt <= row_cnt + addr_w'(1);
                end
              end else begin
                nib_cnt <= nib_cnt + 6'd1;
              end
            end
          end
          default: state <= st_idle;
        endcase
      end
    end
  end

  // *************************************************************************
  // row assembly, msb nibble arrives first
  // *************************************************************************

  always_ff @(posedge clk_sys) begin
    wr_addr <= row_cnt;  // one behind so it lines up with the strobe
    if (rx_take && (state == st_data) && hex[4]) begin
      if (tgt == tgt_dc) begin
        row_data.wide[(gpgpu_loader_pkg::wide_w - 1) - 4 * nib_cnt -: 4] <= hex[3:0];
      end else begin
        row_data.narrow.word[(gpgpu_loader_pkg::narrow_w - 1) - 4 * nib_cnt -: 4] <= hex[3:0];
      end
    end
  end

endmodule
